/* src/ram_bridge_cfg.svh */
`ifndef RAM_BRIDGE_CFG_SVH
`define RAM_BRIDGE_CFG_SVH

// Data word shared by the AXI ports and the RAM.
`define RAM_DATA_W 32

// AXI byte address width.
`define RAM_ADDR_W 16

// AXI burst length field, beats minus one.
`define AXI_LEN_W 8

// Arbiter requesters. The last one is the write port.
`define NUM_REQ 4

// Depth of the simulation RAM in words.
`define RAM_WORDS 256

`endif

/* src/axi_pkg.sv */
package axi_pkg;

`include "ram_bridge_cfg.svh"

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Address as seen on AR and AW.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Raw byte address, or word index plus byte offset.
    typedef union packed {
        logic [`RAM_ADDR_W-1:0] raw;
        struct packed {
            logic [`RAM_ADDR_W-$clog2(`RAM_DATA_W/8)-1:0] word;
            logic [$clog2(`RAM_DATA_W/8)-1:0]              offset;
        } f;
    } axi_addr_u;

    // Burst length, beats minus one.
    typedef logic [`AXI_LEN_W-1:0] axi_len_t;

endpackage

/* src/ram_pkg.sv */
package ram_pkg;

`include "ram_bridge_cfg.svh"

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Single-port RAM side.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Word address, byte offset already dropped.
    typedef logic [`RAM_ADDR_W-$clog2(`RAM_DATA_W/8)-1:0] ram_addr_t;

    typedef logic [`RAM_DATA_W-1:0] ram_data_t;

    // One enable per byte lane.
    typedef logic [`RAM_DATA_W/8-1:0] ram_strb_t;

    // Read ports first, write port last.
    typedef logic [$clog2(`NUM_REQ)-1:0] req_idx_t;

endpackage

/* src/axi_rd_bridge.sv */
module axi_rd_bridge (
    input  logic               clk,
    input  logic               i_reset,
    input  logic               i_arvalid,
    input  axi_pkg::axi_addr_u i_araddr,
    input  axi_pkg::axi_len_t  i_arlen,
    output logic               o_arready,
    output logic               o_rvalid,
    output ram_pkg::ram_data_t o_rdata,
    output logic               o_rlast,
    input  logic               i_rready,
    output logic               o_req,
    output ram_pkg::ram_addr_t o_addr,
    input  logic               i_gnt,
    input  logic               i_rd_valid,
    input  ram_pkg::ram_data_t i_rd_data
);
    import axi_pkg::*;
    import ram_pkg::*;

    enum logic [1:0] {st_idle, st_req, st_wait, st_beat} state;

    ram_addr_t word_addr;
    axi_len_t  beats_left;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // One RAM read per beat, next read after R is taken.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (i_reset) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (i_arvalid) begin
                        state <= st_req;
                    end
                end
                st_req: begin
                    if (i_gnt) begin
                        state <= st_wait;
                    end
                end
                st_wait: begin
                    // RAM answers one cycle after the grant.
                    if (i_rd_valid) begin
                        state <= st_beat;
                    end
                end
                default: begin
                    if (i_rready) begin
                        state <= (beats_left == '0) ? st_idle : st_req;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (o_arready && i_arvalid) begin
            word_addr  <= i_araddr.f.word;
            beats_left <= i_arlen;
        end else if (o_rvalid && i_rready) begin
            word_addr  <= word_addr + 1'b1;
            beats_left <= beats_left - 1'b1;
        end
        if (i_rd_valid) begin
            o_rdata <= i_rd_data;
        end
    end

    assign o_arready = (state == st_idle);
    assign o_req     = (state == st_req);
    assign o_addr    = word_addr;
    assign o_rvalid  = (state == st_beat);
    assign o_rlast   = o_rvalid && (beats_left == '0);

    // The master keeps AR steady until it is taken.
    a_ar_stable: assert property (@(posedge clk) disable iff (i_reset)
        i_arvalid && !o_arready |=> i_arvalid && $stable(i_araddr) && $stable(i_arlen));

    // Only word-aligned bursts are supported.
    a_ar_aligned: assert property (@(posedge clk) disable iff (i_reset)
        i_arvalid && o_arready |-> i_araddr.f.offset == '0);

    a_r_hold: assert property (@(posedge clk) disable iff (i_reset)
        o_rvalid && !i_rready |=> o_rvalid && $stable(o_rdata) && $stable(o_rlast));

endmodule

/* src/axi_wr_bridge.sv */
module axi_wr_bridge (
    input  logic               clk,
    input  logic               i_reset,
    input  logic               i_awvalid,
    input  axi_pkg::axi_addr_u i_awaddr,
    input  axi_pkg::axi_len_t  i_awlen,
    output logic               o_awready,
    input  logic               i_wvalid,
    input  ram_pkg::ram_data_t i_wdata,
    input  ram_pkg::ram_strb_t i_wstrb,
    output logic               o_wready,
    output logic               o_bvalid,
    input  logic               i_bready,
    output logic               o_req,
    output ram_pkg::ram_addr_t o_addr,
    output ram_pkg::ram_data_t o_wdata,
    output ram_pkg::ram_strb_t o_wstrb,
    input  logic               i_gnt
);
    import axi_pkg::*;
    import ram_pkg::*;

    enum logic [1:0] {st_idle, st_data, st_req, st_resp} state;

    ram_addr_t word_addr;
    axi_len_t  beats_left;
    ram_data_t hold_data;
    ram_strb_t hold_strb;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Burst control. One W beat is held at a time.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (i_reset) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (i_awvalid) begin
                        state <= st_data;
                    end
                end
                st_data: begin
                    if (i_wvalid) begin
                        state <= st_req;
                    end
                end
                st_req: begin
                    // Beat count decides the end, WLAST is not used.
                    if (i_gnt) begin
                        state <= (beats_left == '0) ? st_resp : st_data;
                    end
                end
                default: begin
                    if (i_bready) begin
                        state <= st_idle;
                    end
                end
            endcase
        end
    end

    // Address, count and the held beat.
    always_ff @(posedge clk) begin
        if (o_awready && i_awvalid) begin
            word_addr  <= i_awaddr.f.word;
            beats_left <= i_awlen;
        end else if (o_req && i_gnt) begin
            word_addr  <= word_addr + 1'b1;
            beats_left <= beats_left - 1'b1;
        end
        if (o_wready && i_wvalid) begin
            hold_data <= i_wdata;
            hold_strb <= i_wstrb;
        end
    end

    assign o_awready = (state == st_idle);
    assign o_wready  = (state == st_data);
    assign o_req     = (state == st_req);
    assign o_bvalid  = (state == st_resp);
    assign o_addr    = word_addr;
    assign o_wdata   = hold_data;
    assign o_wstrb   = hold_strb;

    a_aw_aligned: assert property (@(posedge clk) disable iff (i_reset)
        i_awvalid && o_awready |-> i_awaddr.f.offset == '0);

    // Response stays up until the master takes it.
    a_b_hold: assert property (@(posedge clk) disable iff (i_reset)
        o_bvalid && !i_bready |=> o_bvalid);

endmodule

/* src/ram_arbiter.sv */
`include "ram_bridge_cfg.svh"

module ram_arbiter (
    input  logic               clk,
    input  logic               i_reset,
    input  logic               i_rd_req [`NUM_REQ-1],
    input  ram_pkg::ram_addr_t i_rd_addr [`NUM_REQ-1],
    output logic               o_rd_gnt [`NUM_REQ-1],
    output logic               o_rd_valid [`NUM_REQ-1],
    output ram_pkg::ram_data_t o_rd_data,
    input  logic               i_wr_req,
    input  ram_pkg::ram_addr_t i_wr_addr,
    input  ram_pkg::ram_data_t i_wr_data,
    input  ram_pkg::ram_strb_t i_wr_strb,
    output logic               o_wr_gnt,
    output logic               o_ram_ren,
    output logic               o_ram_wen,
    output ram_pkg::ram_addr_t o_ram_addr,
    output ram_pkg::ram_data_t o_ram_wdata,
    output ram_pkg::ram_strb_t o_ram_wstrb,
    input  ram_pkg::ram_data_t i_ram_rdata
);
    import ram_pkg::*;

    logic [`NUM_REQ-1:0] req;
    logic [`NUM_REQ-1:0] gnt;
    req_idx_t            ptr;
    req_idx_t            cand;
    req_idx_t            gnt_idx;
    logic                rd_pend;
    req_idx_t            rd_sel;

    always_comb begin
        for (int k = 0; k < `NUM_REQ-1; k++) begin
            req[k] = i_rd_req[k];
        end
        req[`NUM_REQ-1] = i_wr_req;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Round robin, search starts at ptr.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        gnt     = '0;
        gnt_idx = ptr;
        cand    = ptr;
        for (int i = 0; i < `NUM_REQ; i++) begin
            cand = ptr + req_idx_t'(i);
            if (gnt == '0 && req[cand]) begin
                gnt[cand] = 1'b1;
                gnt_idx   = cand;
            end
        end
    end

    always_comb begin
        o_ram_addr = i_wr_addr;
        for (int k = 0; k < `NUM_REQ-1; k++) begin
            o_rd_gnt[k]   = gnt[k];
            o_rd_valid[k] = rd_pend && (rd_sel == req_idx_t'(k));
            if (gnt[k]) begin
                o_ram_addr = i_rd_addr[k];
            end
        end
        o_wr_gnt = gnt[`NUM_REQ-1];
    end

    assign o_ram_ren   = |gnt[`NUM_REQ-2:0];
    assign o_ram_wen   = o_wr_gnt;
    assign o_ram_wdata = i_wr_data;
    assign o_ram_wstrb = i_wr_strb;
    assign o_rd_data   = i_ram_rdata;

    // Priority moves past the last winner.
    always_ff @(posedge clk) begin
        if (i_reset) begin
            ptr     <= '0;
            rd_pend <= 1'b0;
        end else begin
            if (|gnt) begin
                ptr <= gnt_idx + 1'b1;
            end
            rd_pend <= o_ram_ren;
        end
    end

    // Remember which read port gets the data next cycle.
    always_ff @(posedge clk) begin
        if (o_ram_ren) begin
            rd_sel <= gnt_idx;
        end
    end

    a_one_gnt: assert property (@(posedge clk) disable iff (i_reset)
        $onehot0({o_wr_gnt, o_rd_gnt[2], o_rd_gnt[1], o_rd_gnt[0]}));

endmodule

/* src/axi_ram_top.sv */
`include "ram_bridge_cfg.svh"

module axi_ram_top (
    input  logic               clk,
    input  logic               i_reset,
    input  logic               i_rd0_arvalid,
    input  axi_pkg::axi_addr_u i_rd0_araddr,
    input  axi_pkg::axi_len_t  i_rd0_arlen,
    input  logic               i_rd0_rready,
    output logic               o_rd0_arready,
    output logic               o_rd0_rvalid,
    output ram_pkg::ram_data_t o_rd0_rdata,
    output logic               o_rd0_rlast,
    input  logic               i_rd1_arvalid,
    input  axi_pkg::axi_addr_u i_rd1_araddr,
    input  axi_pkg::axi_len_t  i_rd1_arlen,
    input  logic               i_rd1_rready,
    output logic               o_rd1_arready,
    output logic               o_rd1_rvalid,
    output ram_pkg::ram_data_t o_rd1_rdata,
    output logic               o_rd1_rlast,
    input  logic               i_rd2_arvalid,
    input  axi_pkg::axi_addr_u i_rd2_araddr,
    input  axi_pkg::axi_len_t  i_rd2_arlen,
    input  logic               i_rd2_rready,
    output logic               o_rd2_arready,
    output logic               o_rd2_rvalid,
    output ram_pkg::ram_data_t o_rd2_rdata,
    output logic               o_rd2_rlast,
    input  logic               i_wr_awvalid,
    input  axi_pkg::axi_addr_u i_wr_awaddr,
    input  axi_pkg::axi_len_t  i_wr_awlen,
    input  logic               i_wr_wvalid,
    input  ram_pkg::ram_data_t i_wr_wdata,
    input  ram_pkg::ram_strb_t i_wr_wstrb,
    input  logic               i_wr_bready,
    output logic               o_wr_awready,
    output logic               o_wr_wready,
    output logic               o_wr_bvalid,
    output logic               o_ram_ren,
    output logic               o_ram_wen,
    output ram_pkg::ram_addr_t o_ram_addr,
    output ram_pkg::ram_data_t o_ram_wdata,
    output ram_pkg::ram_strb_t o_ram_wstrb,
    input  ram_pkg::ram_data_t i_ram_rdata
);
    import ram_pkg::*;

    logic      rd_req [`NUM_REQ-1];
    ram_addr_t rd_addr [`NUM_REQ-1];
    logic      rd_gnt [`NUM_REQ-1];
    logic      rd_valid [`NUM_REQ-1];
    ram_data_t rd_data;
    logic      wr_req;
    logic      wr_gnt;
    ram_addr_t wr_addr;
    ram_data_t wr_data;
    ram_strb_t wr_strb;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read ports.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    axi_rd_bridge u_rd0 (
        .clk(clk), .i_reset(i_reset),
        .i_arvalid(i_rd0_arvalid), .i_araddr(i_rd0_araddr), .i_arlen(i_rd0_arlen),
        .o_arready(o_rd0_arready), .o_rvalid(o_rd0_rvalid), .o_rdata(o_rd0_rdata),
        .o_rlast(o_rd0_rlast), .i_rready(i_rd0_rready),
        .o_req(rd_req[0]), .o_addr(rd_addr[0]), .i_gnt(rd_gnt[0]),
        .i_rd_valid(rd_valid[0]), .i_rd_data(rd_data)
    );

    axi_rd_bridge u_rd1 (
        .clk(clk), .i_reset(i_reset),
        .i_arvalid(i_rd1_arvalid), .i_araddr(i_rd1_araddr), .i_arlen(i_rd1_arlen),
        .o_arready(o_rd1_arready), .o_rvalid(o_rd1_rvalid), .o_rdata(o_rd1_rdata),
        .o_rlast(o_rd1_rlast), .i_rready(i_rd1_rready),
        .o_req(rd_req[1]), .o_addr(rd_addr[1]), .i_gnt(rd_gnt[1]),
        .i_rd_valid(rd_valid[1]), .i_rd_data(rd_data)
    );

    axi_rd_bridge u_rd2 (
        .clk(clk), .i_reset(i_reset),
        .i_arvalid(i_rd2_arvalid), .i_araddr(i_rd2_araddr), .i_arlen(i_rd2_arlen),
        .o_arready(o_rd2_arready), .o_rvalid(o_rd2_rvalid), .o_rdata(o_rd2_rdata),
        .o_rlast(o_rd2_rlast), .i_rready(i_rd2_rready),
        .o_req(rd_req[2]), .o_addr(rd_addr[2]), .i_gnt(rd_gnt[2]),
        .i_rd_valid(rd_valid[2]), .i_rd_data(rd_data)
    );

    // Write port.
    axi_wr_bridge u_wr (
        .clk(clk), .i_reset(i_reset),
        .i_awvalid(i_wr_awvalid), .i_awaddr(i_wr_awaddr), .i_awlen(i_wr_awlen),
        .o_awready(o_wr_awready), .i_wvalid(i_wr_wvalid), .i_wdata(i_wr_wdata),
        .i_wstrb(i_wr_wstrb), .o_wready(o_wr_wready),
        .o_bvalid(o_wr_bvalid), .i_bready(i_wr_bready),
        .o_req(wr_req), .o_addr(wr_addr), .o_wdata(wr_data), .o_wstrb(wr_strb),
        .i_gnt(wr_gnt)
    );

    // Shared RAM port.
    ram_arbiter u_arb (
        .clk(clk), .i_reset(i_reset),
        .i_rd_req(rd_req), .i_rd_addr(rd_addr), .o_rd_gnt(rd_gnt),
        .o_rd_valid(rd_valid), .o_rd_data(rd_data),
        .i_wr_req(wr_req), .i_wr_addr(wr_addr), .i_wr_data(wr_data),
        .i_wr_strb(wr_strb), .o_wr_gnt(wr_gnt),
        .o_ram_ren(o_ram_ren), .o_ram_wen(o_ram_wen), .o_ram_addr(o_ram_addr),
        .o_ram_wdata(o_ram_wdata), .o_ram_wstrb(o_ram_wstrb),
        .i_ram_rdata(i_ram_rdata)
    );

endmodule

/* dv/axi_ram_tb.sv */
`include "ram_bridge_cfg.svh"

module axi_ram_tb;
    import axi_pkg::*;
    import ram_pkg::*;

    localparam int RAM_IDX_W = $clog2(`RAM_WORDS);
    localparam int HS_LIMIT  = 64;
    // Beats of all bursts below, summed by hand.
    localparam int TOTAL_BEATS     = 108;
    localparam int WATCHDOG_CYCLES = TOTAL_BEATS * 20 + 200;

    typedef logic [RAM_IDX_W-1:0]   word_idx_t;
    typedef logic [1:0]             port_idx_t;
    typedef logic [`RAM_ADDR_W-1:0] byte_addr_t;

    logic      clk;
    logic      i_reset;
    logic      rd_arvalid [3];
    axi_addr_u rd_araddr [3];
    axi_len_t  rd_arlen [3];
    logic      rd_rready [3];
    logic      rd_arready [3];
    logic      rd_rvalid [3];
    ram_data_t rd_rdata [3];
    logic      rd_rlast [3];
    logic      wr_awvalid;
    axi_addr_u wr_awaddr;
    axi_len_t  wr_awlen;
    logic      wr_wvalid;
    ram_data_t wr_wdata;
    ram_strb_t wr_wstrb;
    logic      wr_bready;
    logic      wr_awready;
    logic      wr_wready;
    logic      wr_bvalid;
    logic      ram_ren;
    logic      ram_wen;
    ram_addr_t ram_addr;
    ram_data_t ram_wdata;
    ram_strb_t ram_wstrb;
    ram_data_t ram_rdata;

    ram_data_t mem [`RAM_WORDS];
    ram_data_t shadow [`RAM_WORDS];
    ram_data_t wbeat_data [$];
    ram_strb_t wbeat_strb [$];
    int        errors = 0;
    int        checks = 0;

    axi_ram_top u_dut (
        .clk(clk), .i_reset(i_reset),
        .i_rd0_arvalid(rd_arvalid[0]), .i_rd0_araddr(rd_araddr[0]), .i_rd0_arlen(rd_arlen[0]),
        .i_rd0_rready(rd_rready[0]), .o_rd0_arready(rd_arready[0]),
        .o_rd0_rvalid(rd_rvalid[0]), .o_rd0_rdata(rd_rdata[0]), .o_rd0_rlast(rd_rlast[0]),
        .i_rd1_arvalid(rd_arvalid[1]), .i_rd1_araddr(rd_araddr[1]), .i_rd1_arlen(rd_arlen[1]),
        .i_rd1_rready(rd_rready[1]), .o_rd1_arready(rd_arready[1]),
        .o_rd1_rvalid(rd_rvalid[1]), .o_rd1_rdata(rd_rdata[1]), .o_rd1_rlast(rd_rlast[1]),
        .i_rd2_arvalid(rd_arvalid[2]), .i_rd2_araddr(rd_araddr[2]), .i_rd2_arlen(rd_arlen[2]),
        .i_rd2_rready(rd_rready[2]), .o_rd2_arready(rd_arready[2]),
        .o_rd2_rvalid(rd_rvalid[2]), .o_rd2_rdata(rd_rdata[2]), .o_rd2_rlast(rd_rlast[2]),
        .i_wr_awvalid(wr_awvalid), .i_wr_awaddr(wr_awaddr), .i_wr_awlen(wr_awlen),
        .i_wr_wvalid(wr_wvalid), .i_wr_wdata(wr_wdata), .i_wr_wstrb(wr_wstrb),
        .i_wr_bready(wr_bready), .o_wr_awready(wr_awready), .o_wr_wready(wr_wready),
        .o_wr_bvalid(wr_bvalid),
        .o_ram_ren(ram_ren), .o_ram_wen(ram_wen), .o_ram_addr(ram_addr),
        .o_ram_wdata(ram_wdata), .o_ram_wstrb(ram_wstrb), .i_ram_rdata(ram_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic word_idx_t widx(input int a);
        return word_idx_t'(a);
    endfunction

    // Initial contents, different for every word.
    function automatic ram_data_t fill_word(input int a);
        return ram_data_t'({8'h5a ^ a[7:0], a[7:0], ~a[7:0], a[7:0] + 8'h11});
    endfunction

    function automatic ram_data_t merge_bytes(input ram_data_t old_w, input ram_data_t new_w,
                                              input ram_strb_t strb);
        ram_data_t res;
        res = old_w;
        for (int i = 0; i < `RAM_DATA_W / 8; i++) begin
            if (strb[i]) begin
                res[i*8 +: 8] = new_w[i*8 +: 8];
            end
        end
        return res;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Single-port RAM model.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin : ram_model
        logic      acc_ren;
        logic      acc_wen;
        word_idx_t acc_idx;
        ram_data_t acc_wdata;
        ram_strb_t acc_strb;
        ram_rdata = '0;
        for (int i = 0; i < `RAM_WORDS; i++) begin
            mem[widx(i)] = fill_word(i);
        end
        forever begin
            @(negedge clk);
            acc_ren   = ram_ren;
            acc_wen   = ram_wen;
            acc_idx   = ram_addr[RAM_IDX_W-1:0];
            acc_wdata = ram_wdata;
            acc_strb  = ram_wstrb;
            @(posedge clk);
            #10;
            if (acc_wen) begin
                mem[acc_idx] = merge_bytes(mem[acc_idx], acc_wdata, acc_strb);
            end
            if (acc_ren) begin
                ram_rdata = mem[acc_idx];
            end
        end
    end

    task automatic step_cycle();
        @(posedge clk);
        #10;
    endtask

    task automatic check_data(input string what, input ram_data_t exp, input ram_data_t got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s expected %h got %h", $time, what, exp, got);
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s expected %b got %b", $time, what, exp, got);
        end
    endtask

    task automatic report_hang(input string what);
        errors++;
        $display("%s did not complete within %0d cycles at time %0t", what, HS_LIMIT, $time);
    endtask

    task automatic random_beats(input int beats);
        wbeat_data.delete();
        wbeat_strb.delete();
        for (int b = 0; b < beats; b++) begin
            wbeat_data.push_back($urandom);
            wbeat_strb.push_back('1);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Burst drivers, starting and ending 10 units after a rising edge.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic read_burst(input port_idx_t port, input int word, input int beats,
                              input bit stall);
        axi_addr_u addr;
        ram_data_t held;
        bit        seen;
        bit        taken;
        int        waited;
        // Byte address of the first word.
        addr.raw         = byte_addr_t'(word * (`RAM_DATA_W / 8));
        rd_araddr[port]  = addr;
        rd_arlen[port]   = axi_len_t'(beats - 1);
        rd_arvalid[port] = 1'b1;
        waited = 0;
        @(negedge clk);
        while (!rd_arready[port] && waited < HS_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!rd_arready[port]) begin
            report_hang($sformatf("AR on read port %0d", port));
            step_cycle();
            rd_arvalid[port] = 1'b0;
            return;
        end
        step_cycle();
        rd_arvalid[port] = 1'b0;
        for (int b = 0; b < beats; b++) begin
            seen   = 1'b0;
            taken  = 1'b0;
            waited = 0;
            while (!taken) begin
                rd_rready[port] = stall ? (($urandom % 3) != 0) : 1'b1;
                @(negedge clk);
                // A stalled beat must stay put.
                if (seen) begin
                    check_flag($sformatf("rd%0d rvalid held", port), 1'b1, rd_rvalid[port]);
                    check_data($sformatf("rd%0d rdata held", port), held, rd_rdata[port]);
                end
                if (rd_rvalid[port] && rd_rready[port]) begin
                    check_data($sformatf("rd%0d beat %0d data", port, b),
                               shadow[widx(word + b)], rd_rdata[port]);
                    check_flag($sformatf("rd%0d beat %0d rlast", port, b),
                               logic'(b == beats - 1), rd_rlast[port]);
                    taken = 1'b1;
                end else if (rd_rvalid[port]) begin
                    seen = 1'b1;
                    held = rd_rdata[port];
                end
                if (!taken) begin
                    waited++;
                    if (waited > HS_LIMIT) begin
                        report_hang($sformatf("Beat %0d on read port %0d", b, port));
                        step_cycle();
                        rd_rready[port] = 1'b0;
                        return;
                    end
                end
                step_cycle();
            end
        end
        rd_rready[port] = 1'b0;
        @(negedge clk);
        check_flag($sformatf("rd%0d rvalid after burst", port), 1'b0, rd_rvalid[port]);
        check_flag($sformatf("rd%0d arready after burst", port), 1'b1, rd_arready[port]);
        step_cycle();
    endtask

    task automatic write_burst(input int word, input int beats, input int bready_delay);
        axi_addr_u addr;
        int        waited;
        addr.raw   = byte_addr_t'(word * (`RAM_DATA_W / 8));
        wr_awaddr  = addr;
        wr_awlen   = axi_len_t'(beats - 1);
        wr_awvalid = 1'b1;
        waited = 0;
        @(negedge clk);
        while (!wr_awready && waited < HS_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!wr_awready) begin
            report_hang("AW on the write port");
            step_cycle();
            wr_awvalid = 1'b0;
            return;
        end
        step_cycle();
        wr_awvalid = 1'b0;
        for (int b = 0; b < beats; b++) begin
            wr_wvalid = 1'b1;
            wr_wdata  = wbeat_data[b];
            wr_wstrb  = wbeat_strb[b];
            waited    = 0;
            @(negedge clk);
            if (b > 0) begin
                check_flag("wready before grant", 1'b0, wr_wready);
            end
            while (!wr_wready && waited < HS_LIMIT) begin
                @(negedge clk);
                waited++;
            end
            if (!wr_wready) begin
                report_hang($sformatf("Write beat %0d", b));
                step_cycle();
                wr_wvalid = 1'b0;
                return;
            end
            shadow[widx(word + b)] = merge_bytes(shadow[widx(word + b)], wbeat_data[b],
                                                 wbeat_strb[b]);
            step_cycle();
            wr_wvalid = 1'b0;
        end
        waited = 0;
        @(negedge clk);
        while (!wr_bvalid && waited < HS_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!wr_bvalid) begin
            report_hang("B response on the write port");
            step_cycle();
            return;
        end
        for (int d = 0; d < bready_delay; d++) begin
            step_cycle();
            @(negedge clk);
            check_flag("bvalid while bready low", 1'b1, wr_bvalid);
        end
        step_cycle();
        wr_bready = 1'b1;
        step_cycle();
        wr_bready = 1'b0;
        @(negedge clk);
        check_flag("bvalid after response", 1'b0, wr_bvalid);
        check_flag("awready after response", 1'b1, wr_awready);
        step_cycle();
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Directed tests.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic idle_levels();
        @(negedge clk);
        for (int k = 0; k < 3; k++) begin
            check_flag($sformatf("rd%0d arready after reset", k), 1'b1, rd_arready[k]);
            check_flag($sformatf("rd%0d rvalid after reset", k), 1'b0, rd_rvalid[k]);
        end
        check_flag("awready after reset", 1'b1, wr_awready);
        check_flag("wready after reset", 1'b0, wr_wready);
        check_flag("bvalid after reset", 1'b0, wr_bvalid);
        repeat (3) begin
            check_flag("ram ren while idle", 1'b0, ram_ren);
            check_flag("ram wen while idle", 1'b0, ram_wen);
            @(negedge clk);
        end
        step_cycle();
    endtask

    task automatic write_then_read();
        random_beats(8);
        write_burst(16, 8, 3);
        for (int k = 0; k < 3; k++) begin
            read_burst(port_idx_t'(k), 16, 8, 1'b0);
        end
    endtask

    task automatic byte_strobe_merge();
        random_beats(4);
        write_burst(32, 4, 0);
        random_beats(4);
        wbeat_strb[0] = 4'b0101;
        wbeat_strb[1] = 4'b1010;
        wbeat_strb[2] = 4'b0001;
        wbeat_strb[3] = 4'b1110;
        write_burst(32, 4, 1);
        read_burst(2'd0, 32, 4, 1'b0);
    endtask

    task automatic read_backpressure();
        for (int k = 0; k < 3; k++) begin
            read_burst(port_idx_t'(k), 16, 8, 1'b1);
        end
    endtask

    task automatic four_port_contention();
        random_beats(8);
        fork
            read_burst(2'd0, 64, 8, 1'b1);
            read_burst(2'd1, 72, 8, 1'b1);
            read_burst(2'd2, 80, 8, 1'b1);
            write_burst(96, 8, 2);
        join
        read_burst(2'd1, 96, 8, 1'b0);
    endtask

    initial begin
        void'($urandom(32'hbb0adeb0));
        i_reset = 1'b1;
        for (int k = 0; k < 3; k++) begin
            rd_arvalid[k] = 1'b0;
            rd_araddr[k]  = '0;
            rd_arlen[k]   = '0;
            rd_rready[k]  = 1'b0;
        end
        wr_awvalid = 1'b0;
        wr_awaddr  = '0;
        wr_awlen   = '0;
        wr_wvalid  = 1'b0;
        wr_wdata   = '0;
        wr_wstrb   = '0;
        wr_bready  = 1'b0;
        for (int i = 0; i < `RAM_WORDS; i++) begin
            shadow[widx(i)] = fill_word(i);
        end
        repeat (5) @(posedge clk);
        #10;
        i_reset = 1'b0;
        idle_levels();
        write_then_read();
        byte_strobe_merge();
        read_backpressure();
        four_port_contention();
        $display("Checks: %0d  Errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
        $display("Checks: %0d  Errors: %0d", checks, errors + 1);
        $display("Result: FAILED");
        $finish;
    end

endmodule

/* src.f */
+incdir+src
src/axi_pkg.sv
src/ram_pkg.sv
src/axi_rd_bridge.sv
src/axi_wr_bridge.sv
src/ram_arbiter.sv
src/axi_ram_top.sv
dv/axi_ram_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the AXI RAM bridge testbench with Verilator.
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    -f src.f \
    --top-module axi_ram_tb \
    -Mdir obj_dir \
    -o axi_ram_sim

./obj_dir/axi_ram_sim | tee sim.log

if grep -q "Result: FAILED" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
echo "Simulation finished without failure"
